//--- Bender.yml
package:
  name: board_top

sources:
  - files:
      - source/board_pkg.sv
      - source/apb_host_port.sv
      - source/input_sampler.sv
      - source/reg_bus_arbiter.sv
      - source/board_regs.sv
      - source/seven_seg_driver.sv
      - source/board_top.sv
  - target: test
    files:
      - test/board_assertions.sv
      - test/tb_board_top.sv

//--- source/apb_host_port.sv
// APB slave with 32-bit accesses only (no PSTRB); the master must drop penable after pready
`timescale 1ns/1ps

module apb_host_port (
	input  logic                CLK,
	input  logic                reset,
	// APB slave
	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  logic [15:0]         paddr,
	input  logic [31:0]         pwdata,
	output logic [31:0]         prdata,
	output logic                pready,
	output logic                pslverr,
	// Register bus peer
	output board_pkg::reg_req_t host_req,
	input  board_pkg::reg_rsp_t host_rsp
);
	import board_pkg::*;

	logic access_phase;
	logic done_q;

	// Request only in the access phase
	assign access_phase = psel & penable;

	// Remember the completion for one cycle
	// so a slow penable drop cannot repeat the access
	always_ff @(posedge CLK) begin
		if (reset) begin
			done_q <= 1'b0;
		end else begin
			done_q <= host_rsp.done;
		end
	end

	// ==============================
	// Request forming
	// ==============================
	always_comb begin
		host_req.valid = access_phase & ~done_q;
		host_req.op    = pwrite ? OP_WRITE : OP_READ;
		host_req.addr  = paddr;
		host_req.wdata = pwdata;
	end

	// Response straight back to APB
	// arbiter keeps these at zero unless the host was granted
	assign pready  = host_rsp.done;
	assign prdata  = host_rsp.rdata;
	assign pslverr = host_rsp.err;

endmodule

//--- source/board_pkg.sv
// Shared bus types, offsets and sizes for the board; the register bus is 32 bits and only a 16-bit offset is decoded
package board_pkg;

	// ==============================
	// Register bus
	// ==============================

	// Request kinds. Set_bits comes only from the input sampler
	typedef enum logic [1:0] {
		OP_READ     = 2'd0,
		OP_WRITE    = 2'd1,
		OP_SET_BITS = 2'd2
	} bus_op_t;

	typedef struct packed {
		logic        valid;
		bus_op_t     op;
		logic [15:0] addr;
		logic [31:0] wdata;
	} reg_req_t;

	// Done comes back in the same cycle as the grant
	typedef struct packed {
		logic        done;
		logic [31:0] rdata;
		logic        err;
	} reg_rsp_t;

	// Local offsets of the register bank
	localparam logic [15:0] ADDR_LED          = 16'h0000;
	localparam logic [15:0] ADDR_DISPLAY      = 16'h0004;
	localparam logic [15:0] ADDR_SWITCH       = 16'h0008;
	localparam logic [15:0] ADDR_BUTTON_EVENT = 16'h000C;
	localparam logic [15:0] ADDR_INTR_EN      = 16'h0010;

	// Host gets the bus after this many cycles lost to the sampler
	localparam int HOST_STALL_LIMIT = 2;

	// ==============================
	// Board pins and display
	// ==============================

	localparam int LED_BITS       = 8;
	localparam int SWITCH_BITS    = 8;
	localparam int BUTTON_BITS    = 9;
	localparam int DIGITS         = 4;
	localparam int SEG_PINS       = 14;
	localparam int DISPLAY_BITS   = 4 * DIGITS;
	localparam int DIGIT_IDX_BITS = $clog2(DIGITS);

	// Clocks per lit digit, kept small for simulation
	localparam int SCAN_CYCLES   = 4;
	localparam int SCAN_CNT_BITS = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

	// Common anode display, every pin active low
	typedef struct packed {
		logic [6:0]        seg;
		logic              dp;
		logic [DIGITS-1:0] dig;
		logic [1:0]        colon;
	} seg_pins_t;

	// Hex digit to segments a..g in bits 0..6, active low
	function automatic logic [6:0] seg_encode(input logic [3:0] nibble);
		logic [6:0] lit;
		case (nibble)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h6F;
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

endpackage

//--- source/board_regs.sv
// Single-cycle register bank; SWITCH is read-only and BUTTON_EVENT is set by the sampler, cleared by writing ones
`timescale 1ns/1ps

module board_regs (
	input  logic                               CLK,
	input  logic                               reset,
	input  board_pkg::reg_req_t                bus_req,
	output board_pkg::reg_rsp_t                bus_rsp,
	input  logic [board_pkg::SWITCH_BITS-1:0]  switch_sync,
	output logic [board_pkg::LED_BITS-1:0]     led,
	output logic [board_pkg::DISPLAY_BITS-1:0] display_value,
	output logic                               intr
);
	import board_pkg::*;

	logic [LED_BITS-1:0]     led_q;
	logic [DISPLAY_BITS-1:0] display_q;
	logic [BUTTON_BITS-1:0]  event_q;
	logic                    intr_en_q;

	logic        hit_led;
	logic        hit_display;
	logic        hit_event;
	logic        hit_intr_en;
	logic        is_write;
	logic        is_set;
	logic        mapped;
	logic [31:0] read_data;

	// ==============================
	// Decode
	// ==============================
	assign hit_led     = (bus_req.addr == ADDR_LED);
	assign hit_display = (bus_req.addr == ADDR_DISPLAY);
	assign hit_event   = (bus_req.addr == ADDR_BUTTON_EVENT);
	assign hit_intr_en = (bus_req.addr == ADDR_INTR_EN);

	assign is_write = bus_req.valid & (bus_req.op == OP_WRITE);
	assign is_set   = bus_req.valid & (bus_req.op == OP_SET_BITS);

	// Host writes replace the register value
	// Event bits are set by the sampler and cleared by host writes of ones
	always_ff @(posedge CLK) begin
		if (reset) begin
			led_q     <= '0;
			display_q <= '0;
			event_q   <= '0;
			intr_en_q <= 1'b0;
		end else begin
			if (hit_led & is_write) begin
				led_q <= bus_req.wdata[LED_BITS-1:0];
			end
			if (hit_display & is_write) begin
				display_q <= bus_req.wdata[DISPLAY_BITS-1:0];
			end
			if (hit_event & is_set) begin
				event_q <= event_q | bus_req.wdata[BUTTON_BITS-1:0];
			end else if (hit_event & is_write) begin
				event_q <= event_q & ~bus_req.wdata[BUTTON_BITS-1:0];
			end
			if (hit_intr_en & is_write) begin
				intr_en_q <= bus_req.wdata[0];
			end
		end
	end

	// ==============================
	// Read mux
	// ==============================
	always_comb begin
		read_data = '0;
		mapped    = 1'b1;
		case (bus_req.addr)
			ADDR_LED:          read_data[LED_BITS-1:0]     = led_q;
			ADDR_DISPLAY:      read_data[DISPLAY_BITS-1:0] = display_q;
			ADDR_SWITCH:       read_data[SWITCH_BITS-1:0]  = switch_sync;
			ADDR_BUTTON_EVENT: read_data[BUTTON_BITS-1:0]  = event_q;
			ADDR_INTR_EN:      read_data[0]                = intr_en_q;
			default:           mapped                      = 1'b0;
		endcase
	end

	// Every request finishes in the cycle it arrives
	assign bus_rsp.done  = bus_req.valid;
	assign bus_rsp.rdata = read_data;
	assign bus_rsp.err   = bus_req.valid & ~mapped;

	assign led           = led_q;
	assign display_value = display_q;
	// Level interrupt held while any event is still set
	assign intr          = intr_en_q & (|event_q);

endmodule

//--- source/board_top.sv
// Board peripheral block behind a 16-bit APB offset; no debouncing and no board models inside
`timescale 1ns/1ps

module board_top (
	input  logic                              CLK,
	input  logic                              reset,
	// APB slave
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [15:0]                       paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	// Board pins
	output logic [board_pkg::LED_BITS-1:0]    led,
	output board_pkg::seg_pins_t              display,
	input  logic [board_pkg::SWITCH_BITS-1:0] switches,
	input  logic [board_pkg::BUTTON_BITS-1:0] buttons,
	output logic                              intr
);
	import board_pkg::*;

	// Register bus, two peers into one bank
	reg_req_t host_req;
	reg_rsp_t host_rsp;
	reg_req_t evt_req;
	reg_rsp_t evt_rsp;
	reg_req_t bus_req;
	reg_rsp_t bus_rsp;

	logic [SWITCH_BITS-1:0]  switch_sync;
	logic [DISPLAY_BITS-1:0] display_value;

	apb_host_port host_port_inst (
		.CLK(CLK), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.host_req(host_req), .host_rsp(host_rsp)
	);

	input_sampler sampler_inst (
		.CLK(CLK), .reset(reset),
		.switches(switches), .buttons(buttons), .switch_sync(switch_sync),
		.evt_req(evt_req), .evt_rsp(evt_rsp)
	);

	// Sampler has priority
	reg_bus_arbiter arbiter_inst (
		.CLK(CLK), .reset(reset),
		.evt_req(evt_req), .host_req(host_req), .evt_rsp(evt_rsp), .host_rsp(host_rsp),
		.bus_req(bus_req), .bus_rsp(bus_rsp)
	);

	board_regs regs_inst (
		.CLK(CLK), .reset(reset),
		.bus_req(bus_req), .bus_rsp(bus_rsp), .switch_sync(switch_sync),
		.led(led), .display_value(display_value), .intr(intr)
	);

	seven_seg_driver seg_driver_inst (
		.CLK(CLK), .reset(reset),
		.display_value(display_value), .display(display)
	);

endmodule

//--- source/input_sampler.sv
// Pins are synchronized but not debounced; every clean rising edge of a button counts as one event
`timescale 1ns/1ps

module input_sampler (
	input  logic                             CLK,
	input  logic                             reset,
	input  logic [board_pkg::SWITCH_BITS-1:0] switches,
	input  logic [board_pkg::BUTTON_BITS-1:0] buttons,
	output logic [board_pkg::SWITCH_BITS-1:0] switch_sync,
	output board_pkg::reg_req_t              evt_req,
	input  board_pkg::reg_rsp_t              evt_rsp
);
	import board_pkg::*;

	// Two flop synchronizer, switches and buttons together
	logic [SWITCH_BITS-1:0] sw_meta;
	logic [SWITCH_BITS-1:0] sw_sync;
	logic [BUTTON_BITS-1:0] btn_meta;
	logic [BUTTON_BITS-1:0] btn_sync;
	logic [BUTTON_BITS-1:0] btn_prev;
	logic [BUTTON_BITS-1:0] btn_rise;
	logic [BUTTON_BITS-1:0] pending;

	always_ff @(posedge CLK) begin
		if (reset) begin
			sw_meta  <= '0;
			sw_sync  <= '0;
			btn_meta <= '0;
			btn_sync <= '0;
			btn_prev <= '0;
		end else begin
			sw_meta  <= switches;
			sw_sync  <= sw_meta;
			btn_meta <= buttons;
			btn_sync <= btn_meta;
			btn_prev <= btn_sync;
		end
	end

	// New presses seen this cycle
	assign btn_rise = btn_sync & ~btn_prev;

	// ==============================
	// Pending event mask
	// ==============================
	// Granted bits leave, edges of the grant cycle stay for the next request
	always_ff @(posedge CLK) begin
		if (reset) begin
			pending <= '0;
		end else if (evt_rsp.done) begin
			pending <= btn_rise;
		end else begin
			pending <= pending | btn_rise;
		end
	end

	always_comb begin
		evt_req.valid = |pending;
		evt_req.op    = OP_SET_BITS;
		evt_req.addr  = ADDR_BUTTON_EVENT;
		evt_req.wdata = {{(32 - BUTTON_BITS){1'b0}}, pending};
	end

	assign switch_sync = sw_sync;

endmodule

//--- source/reg_bus_arbiter.sv
// Fixed priority with the sampler first; the host is forced through after HOST_STALL_LIMIT lost cycles
`timescale 1ns/1ps

module reg_bus_arbiter (
	input  logic                CLK,
	input  logic                reset,
	input  board_pkg::reg_req_t evt_req,
	input  board_pkg::reg_req_t host_req,
	output board_pkg::reg_rsp_t evt_rsp,
	output board_pkg::reg_rsp_t host_rsp,
	output board_pkg::reg_req_t bus_req,
	input  board_pkg::reg_rsp_t bus_rsp
);
	import board_pkg::*;

	logic [1:0] stall_cnt;
	logic       host_first;
	logic       grant_host;
	logic       grant_evt;

	// Starvation guard
	assign host_first = (stall_cnt >= HOST_STALL_LIMIT);

	assign grant_host = host_req.valid & (~evt_req.valid | host_first);
	assign grant_evt  = evt_req.valid & ~grant_host;

	// Count cycles the host lost to the sampler
	always_ff @(posedge CLK) begin
		if (reset) begin
			stall_cnt <= '0;
		end else if (grant_host) begin
			stall_cnt <= '0;
		end else if (host_req.valid) begin
			stall_cnt <= stall_cnt + 2'd1;
		end
	end

	// One request per cycle to the bank
	assign bus_req = grant_host ? host_req : evt_req;

	// Only the granted peer sees the reply
	assign host_rsp = grant_host ? bus_rsp : '0;
	assign evt_rsp  = grant_evt  ? bus_rsp : '0;

endmodule

//--- source/seven_seg_driver.sv
// Scans a common-anode four-digit display; pins are registered and all digits stay off during reset
`timescale 1ns/1ps

module seven_seg_driver (
	input  logic                               CLK,
	input  logic                               reset,
	input  logic [board_pkg::DISPLAY_BITS-1:0] display_value,
	output board_pkg::seg_pins_t               display
);
	import board_pkg::*;

	logic [SCAN_CNT_BITS-1:0]  dwell_cnt;
	logic [DIGIT_IDX_BITS-1:0] digit_idx;
	logic [3:0]                nibble;
	logic [DIGITS-1:0]         digit_sel;
	logic                      dwell_end;

	// Digit 0 is the low nibble
	assign nibble    = display_value[digit_idx*4 +: 4];
	assign dwell_end = (dwell_cnt == SCAN_CNT_BITS'(SCAN_CYCLES - 1));

	// One-hot, active low
	always_comb begin
		digit_sel            = '1;
		digit_sel[digit_idx] = 1'b0;
	end

	// ==============================
	// Scan timing
	// ==============================
	always_ff @(posedge CLK) begin
		if (reset) begin
			dwell_cnt <= '0;
			digit_idx <= '0;
		end else if (dwell_end) begin
			dwell_cnt <= '0;
			if (digit_idx == DIGIT_IDX_BITS'(DIGITS - 1)) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	// Pin register, dp and colon unused so held high
	always_ff @(posedge CLK) begin
		if (reset) begin
			display <= seg_pins_t'({SEG_PINS{1'b1}});
		end else begin
			display.seg   <= seg_encode(nibble);
			display.dp    <= 1'b1;
			display.dig   <= digit_sel;
			display.colon <= 2'b11;
		end
	end

endmodule

//--- tb.f
source/board_pkg.sv
source/apb_host_port.sv
source/input_sampler.sv
source/reg_bus_arbiter.sv
source/board_regs.sv
source/seven_seg_driver.sv
source/board_top.sv
test/board_assertions.sv
test/tb_board_top.sv

//--- test/board_assertions.sv
// Bound into board_top; checks the APB ready rule, one done per cycle and the host wait bound
`timescale 1ns/1ps

module board_assertions (
	input logic                CLK,
	input logic                reset,
	input logic                psel,
	input logic                penable,
	input logic                pready,
	input board_pkg::reg_req_t host_req,
	input board_pkg::reg_rsp_t host_rsp,
	input board_pkg::reg_rsp_t evt_rsp
);
	import board_pkg::*;

	// Ready only inside an access phase
	assert property (@(posedge CLK) disable iff (reset) pready |-> (psel && penable))
		else $error("pready high outside the APB access phase");

	// Arbiter grants one peer per cycle
	assert property (@(posedge CLK) disable iff (reset) !(host_rsp.done && evt_rsp.done))
		else $error("host and sampler both saw done in one cycle");

	// Starvation guard keeps the host wait short
	assert property (@(posedge CLK) disable iff (reset)
		(host_req.valid && !host_rsp.done) [*3] |=> host_rsp.done)
		else $error("host request waited more than three cycles");

endmodule

bind board_top board_assertions board_assertions_inst (
	.CLK(CLK), .reset(reset), .psel(psel), .penable(penable), .pready(pready),
	.host_req(host_req), .host_rsp(host_rsp), .evt_rsp(evt_rsp)
);

//--- test/board_vectors.txt
# columns: op offset data expected error, all hex after op
# set_pins, scan_check and pulse_buttons use the data column only
apb_write     0000 000000a5 00000000 0
apb_read      0000 00000000 000000a5 0
apb_write     0000 ffffff3c 00000000 0
apb_read      0000 00000000 0000003c 0
apb_write     0010 ffffffff 00000000 0
apb_read      0010 00000000 00000001 0
set_pins      0000 0000005a 00000000 0
apb_read      0008 00000000 0000005a 0
pulse_buttons 000c 00000014 00000000 0
event_check   000c 00000000 00000000 0
event_clear   000c 00000000 00000000 0
event_check   000c 00000000 00000000 0
busy_access   0000 00000077 00000077 0
busy_access   0004 0000beef 0000beef 0
event_check   000c 00000000 00000000 0
event_clear   000c 00000000 00000000 0
apb_write     0004 0000c3a9 00000000 0
apb_read      0004 00000000 0000c3a9 0
scan_check    0004 0000c3a9 00000000 0
apb_write     0014 12345678 00000000 1
apb_read      0014 00000000 00000000 1
apb_write     0008 000000ff 00000000 0
apb_read      0008 00000000 0000005a 0

//--- test/tb_board_top.sv
// Vector-driven APB testbench; needs test/board_vectors.txt relative to the run directory
`timescale 1ns/1ps

module tb_board_top;
	import board_pkg::*;

	logic                   CLK;
	logic                   reset;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [15:0]            paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;
	logic [LED_BITS-1:0]    led;
	seg_pins_t              display;
	logic [SWITCH_BITS-1:0] switches;
	logic [BUTTON_BITS-1:0] buttons;
	logic                   intr;

	// Vector storage
	string       vec_op[$];
	logic [15:0] vec_addr[$];
	logic [31:0] vec_data[$];
	logic [31:0] vec_exp[$];
	logic        vec_err[$];

	// Reference state kept from the register rules
	logic [BUTTON_BITS-1:0] event_model = '0;
	logic                   intr_en_model = 1'b0;
	logic                   pulse_on = 1'b0;
	logic [6:0]             seg_lit [16];

	int errors = 0;
	int failed_tests = 0;
	int cycle_count = 0;
	int cycle_limit = 200;

	board_top board_top_inst (
		.CLK(CLK), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.led(led), .display(display), .switches(switches), .buttons(buttons), .intr(intr)
	);

	// 100 ns clock
	always #50 CLK = ~CLK;

	// Run limit
	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("run stopped after %0d cycles without reaching the end", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ==============================
	// Random button pulses
	// ==============================
	initial begin : pulse_gen
		logic [BUTTON_BITS-1:0] pulse;
		buttons = '0;
		void'($urandom(32'h2f7b8892));
		forever begin
			@(posedge CLK);
			pulse = '0;
			// One random button about every other cycle
			if (pulse_on && ($urandom & 1)) pulse[$urandom % BUTTON_BITS] = 1'b1;
			buttons <= pulse;
			event_model = event_model | pulse;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want) else begin
			$display("mismatch %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	// Setup phase, then access phase until pready
	task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		int waited;
		waited = 0;
		rdata  = '0;
		err    = 1'b0;
		@(posedge CLK);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge CLK);
		penable <= 1'b1;
		@(negedge CLK);
		while (!pready && waited < 16) begin
			@(negedge CLK);
			waited++;
		end
		assert (pready) else begin
			$display("APB access to offset %h got no ready within 16 cycles", addr);
			errors++;
		end
		if (pready) begin
			rdata = prdata;
			err   = pslverr;
		end
		@(posedge CLK);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// Four full rounds of the digit scan
	task automatic scan_display(input logic [15:0] value);
		int n;
		int d;
		int k;
		int low_count;
		@(posedge CLK);
		for (n = 0; n < 4 * DIGITS * SCAN_CYCLES; n++) begin
			@(negedge CLK);
			low_count = 0;
			k = 0;
			for (d = 0; d < DIGITS; d++) begin
				if (!display.dig[d]) begin
					low_count++;
					k = d;
				end
			end
			assert (low_count == 1) else begin
				$display("mismatch display.dig: got %h, expected one low select", display.dig);
				errors++;
			end
			if (low_count == 1) begin
				check_value("display.seg", display.seg,
					{25'b0, ~seg_lit[value[k*4 +: 4]]});
			end
			check_value("display.dp", display.dp, 1'b1);
			check_value("display.colon", display.colon, 2'b11);
		end
	endtask

	task automatic load_vectors();
		int fd;
		string line;
		string op;
		logic [31:0] a, d, e, f;
		fd = $fopen("test/board_vectors.txt", "r");
		assert (fd != 0) else begin
			$display("cannot open the vector file test/board_vectors.txt");
			errors++;
		end
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 &&
					$sscanf(line, "%s %h %h %h %h", op, a, d, e, f) == 5) begin
					if (op.substr(0, 0) != "#") begin
						vec_op.push_back(op);
						vec_addr.push_back(a[15:0]);
						vec_data.push_back(d);
						vec_exp.push_back(e);
						vec_err.push_back(f[0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ==============================
	// One vector
	// ==============================
	task automatic run_vector(input int idx);
		string       op;
		logic [15:0] addr;
		logic [31:0] data;
		logic [31:0] exp_value;
		logic [31:0] rdata;
		logic [31:0] clear;
		logic        exp_err;
		logic        err;
		int          errors_before;
		op = vec_op[idx];
		addr = vec_addr[idx];
		data = vec_data[idx];
		exp_value = vec_exp[idx];
		exp_err = vec_err[idx];
		errors_before = errors;
		case (op)
			"apb_write": begin
				apb_access(1'b1, addr, data, rdata, err);
				check_value("pslverr", err, exp_err);
				@(negedge CLK);
				if (addr == ADDR_LED) check_value("led", led, data[LED_BITS-1:0]);
				if (addr == ADDR_INTR_EN && !exp_err) intr_en_model = data[0];
			end
			"apb_read": begin
				apb_access(1'b0, addr, data, rdata, err);
				check_value("prdata", rdata, exp_value);
				check_value("pslverr", err, exp_err);
			end
			"set_pins": begin
				@(posedge CLK);
				switches <= data[SWITCH_BITS-1:0];
				repeat (4) @(posedge CLK);
			end
			"scan_check": scan_display(data[15:0]);
			"pulse_buttons": begin
				@(posedge CLK);
				pulse_on <= 1'b1;
				repeat (data) @(posedge CLK);
				pulse_on <= 1'b0;
				// Let the sampler drain its pending mask
				repeat (8) @(posedge CLK);
			end
			"event_check": begin
				apb_access(1'b0, ADDR_BUTTON_EVENT, '0, rdata, err);
				check_value("prdata", rdata, {23'b0, event_model});
				check_value("pslverr", err, 1'b0);
				@(negedge CLK);
				check_value("intr", intr, intr_en_model & (|event_model));
			end
			"event_clear": begin
				clear = {23'b0, event_model};
				apb_access(1'b1, ADDR_BUTTON_EVENT, clear, rdata, err);
				event_model = event_model & ~clear[BUTTON_BITS-1:0];
				check_value("pslverr", err, 1'b0);
				@(negedge CLK);
				check_value("intr", intr, intr_en_model & (|event_model));
			end
			"busy_access": begin
				// Pulses keep the sampler on the bus during both accesses
				@(posedge CLK);
				pulse_on <= 1'b1;
				apb_access(1'b1, addr, data, rdata, err);
				check_value("pslverr", err, exp_err);
				apb_access(1'b0, addr, '0, rdata, err);
				check_value("prdata", rdata, exp_value);
				check_value("pslverr", err, exp_err);
				@(posedge CLK);
				pulse_on <= 1'b0;
				repeat (8) @(posedge CLK);
			end
			default: begin
				$display("unknown operation %s in vector %0d", op, idx);
				errors++;
			end
		endcase
		if (errors != errors_before) failed_tests++;
		$display("test %0d %s offset %h: %s", idx, op, addr,
			(errors == errors_before) ? "ok" : "error");
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		CLK     = 1'b0;
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		switches = '0;
		// Lit segments a..g per hex digit
		seg_lit = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
			7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
		load_vectors();
		assert (vec_op.size() > 0) else begin
			$display("no vectors were read");
			errors++;
		end
		cycle_limit = vec_op.size() * 64 + 200;
		repeat (8) @(posedge CLK);
		reset <= 1'b0;
		@(negedge CLK);
		check_value("led", led, '0);
		check_value("intr", intr, 1'b0);
		check_value("pready", pready, 1'b0);
		check_value("pslverr", pslverr, 1'b0);
		// All digits off until the first scan step
		check_value("display.dig", display.dig, 4'hF);
		if (errors == 0) begin
			for (int i = 0; i < vec_op.size(); i++) run_vector(i);
		end
		$display("tests %0d, tests with errors %0d, total errors %0d",
			vec_op.size(), failed_tests, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
